//--- verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cache geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int addr_width   = 32;
    localparam int word_width   = 32;
    localparam int offset_width = 2;                       // One 4-byte word per line
    localparam int index_width  = 6;
    localparam int num_lines    = 2 ** index_width;         // 64 lines
    localparam int tag_width    = addr_width - index_width - offset_width;

    // Access size as seen by the load/store unit
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_t;

    // One processor access, held as a level until cache_miss is low
    typedef struct packed {
        logic                  read;
        logic                  write;
        size_t                 size;
        logic                  signed_load;
        logic [addr_width-1:0] addr;
        logic [word_width-1:0] wdata;
    } cpu_req_t;

    // Per-line state kept in the tag array
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [tag_width-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] offset;
    } addr_fields_t;

    // Word request towards the memory port, always a full unsigned word
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [addr_width-1:0] addr;
        logic [word_width-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

//--- verilog/block_array.sv
`default_nettype none

// Line-indexed storage shared by the tag and data arrays of the cache.
// Reads are combinational so a hit can be resolved in the request cycle
module block_array #(
    parameter type entry_t        = logic [31:0],
    parameter bit  clear_on_reset = 1'b0
) (
    input  wire                                 clk,
    input  wire                                 rst,

    // Read port
    input  wire  [dcache_pkg::index_width-1:0]  rd_index,
    output entry_t                              rd_entry,

    // Write port
    input  wire                                 wr_en,
    input  wire  [dcache_pkg::index_width-1:0]  wr_index,
    input  wire  entry_t                        wr_entry
);

    entry_t entries [dcache_pkg::num_lines];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rd_entry = entries[rd_index];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst && clear_on_reset) begin
            // Zeroing the tag entries drops every valid and dirty bit
            for (int i = 0; i < dcache_pkg::num_lines; i++) begin
                entries[i] <= '0;
            end
        end else if (wr_en) begin
            entries[wr_index] <= wr_entry;
        end
    end

endmodule

`default_nettype wire

//--- verilog/access_align.sv
`default_nettype none

// Byte-lane steering between the processor and a cached word.
// Loads pick a lane and extend it, stores patch lanes into the line word
module access_align (
    input  wire  dcache_pkg::cpu_req_t  req,
    input  wire  [31:0]                 line_word,
    output logic [31:0]                 load_data,
    output logic [31:0]                 store_word
);

    dcache_pkg::addr_fields_t fields;
    logic [dcache_pkg::offset_width-1:0] offset;
    logic [4:0] lane_shift;                             // Bit position of the addressed byte
    logic [7:0] lane_byte;
    logic [15:0] lane_half;

    assign fields     = req.addr;
    assign offset     = fields.offset;
    assign lane_shift = {offset, 3'b000};

    // Halfwords sit on even bytes, so offset bit 0 is ignored
    assign lane_byte = line_word[lane_shift +: 8];
    assign lane_half = offset[1] ? line_word[31:16] : line_word[15:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (req.size)
            dcache_pkg::size_byte: begin
                load_data = {{24{req.signed_load & lane_byte[7]}}, lane_byte};
            end
            dcache_pkg::size_half: begin
                load_data = {{16{req.signed_load & lane_half[15]}}, lane_half};
            end
            default: begin
                load_data = line_word;                  // Word loads ignore the offset
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Store path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        store_word = line_word;
        case (req.size)
            dcache_pkg::size_byte: begin
                store_word[lane_shift +: 8] = req.wdata[7:0];
            end
            dcache_pkg::size_half: begin
                if (offset[1]) begin
                    store_word[31:16] = req.wdata[15:0];
                end else begin
                    store_word[15:0] = req.wdata[15:0];
                end
            end
            default: begin
                store_word = req.wdata;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/cache_ctrl.sv
`default_nettype none

// Hit detection and miss sequencing for the direct-mapped cache.
// A miss on a dirty line writes the victim back before the refill
module cache_ctrl (
    input  wire                              clk,
    input  wire                              rst,

    // Processor access and the state of its line
    input  wire  dcache_pkg::cpu_req_t       req,
    input  wire  dcache_pkg::addr_fields_t   fields,
    input  wire  dcache_pkg::tag_entry_t     tag_entry,
    input  wire  [31:0]                      line_word,
    input  wire  [31:0]                      store_word,

    // Memory port
    input  wire                              mmu_mem_ready,
    input  wire  [31:0]                      mmu_data_out,
    output dcache_pkg::mem_req_t             mem_req,

    // Array write ports
    output logic                             tag_wr_en,
    output dcache_pkg::tag_entry_t           tag_wr_entry,
    output logic                             data_wr_en,
    output logic [31:0]                      data_wr_word,

    output logic                             cache_miss
);

    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_writeback = 2'd1,
        st_refill    = 2'd2
    } state_t;

    state_t state;
    state_t state_next;

    logic access;
    logic hit;
    logic miss_now;

    assign access      = req.read || req.write;
    assign hit         = tag_entry.valid && (tag_entry.tag == fields.tag);
    assign miss_now    = access && !hit;

    // Stays high from the miss until the refilled line is seen as a hit
    assign cache_miss = (state != st_idle) || miss_now;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State register and next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (miss_now) begin
                    if (tag_entry.valid && tag_entry.dirty) begin
                        state_next = st_writeback;
                    end else begin
                        state_next = st_refill;
                    end
                end
            end
            st_writeback: begin
                if (mmu_mem_ready) begin
                    state_next = st_refill;         // Victim is safe in memory
                end
            end
            st_refill: begin
                if (mmu_mem_ready) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory requests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        mem_req = '0;
        case (state)
            st_writeback: begin
                // Victim address comes from the stored tag, not the request
                mem_req.write = 1'b1;
                mem_req.addr  = {tag_entry.tag, fields.index, {dcache_pkg::offset_width{1'b0}}};
                mem_req.wdata = line_word;
            end
            st_refill: begin
                mem_req.read = 1'b1;                // Line traffic is word aligned
                mem_req.addr = {fields.tag, fields.index, {dcache_pkg::offset_width{1'b0}}};
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Array updates
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        tag_wr_en    = 1'b0;
        tag_wr_entry = '0;
        data_wr_en   = 1'b0;
        data_wr_word = store_word;

        if (state == st_refill && mmu_mem_ready) begin
            // Install a clean line so that a pending store then hits in idle
            tag_wr_en          = 1'b1;
            tag_wr_entry.valid = 1'b1;
            tag_wr_entry.dirty = 1'b0;
            tag_wr_entry.tag   = fields.tag;
            data_wr_en         = 1'b1;
            data_wr_word       = mmu_data_out;
        end else if (state == st_idle && req.write && hit) begin
            tag_wr_en          = 1'b1;
            tag_wr_entry.valid = 1'b1;
            tag_wr_entry.dirty = 1'b1;
            tag_wr_entry.tag   = fields.tag;
            data_wr_en         = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/l1_data_cache.sv
`default_nettype none

// Direct-mapped write-back L1 data cache, 64 lines of one word each
module l1_data_cache (
    input  wire                         clk,
    input  wire                         rst,

    // Load/store unit
    input  wire  dcache_pkg::cpu_req_t  req,
    output logic                        cache_miss,
    output logic [31:0]                 data_out,

    // Memory port
    input  wire                         mmu_mem_ready,
    input  wire  [31:0]                 mmu_data_out,
    output dcache_pkg::mem_req_t        mem_req
);

    dcache_pkg::addr_fields_t fields;

    dcache_pkg::tag_entry_t tag_rd_entry;
    dcache_pkg::tag_entry_t tag_wr_entry;
    logic                   tag_wr_en;

    logic [dcache_pkg::word_width-1:0] line_word;
    logic [dcache_pkg::word_width-1:0] data_wr_word;
    logic                              data_wr_en;

    logic [31:0] store_word;

    // Tag, index and offset straight from the byte address
    assign fields = req.addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    cache_ctrl ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .fields        (fields),
        .tag_entry     (tag_rd_entry),
        .line_word     (line_word),
        .store_word    (store_word),
        .mmu_mem_ready (mmu_mem_ready),
        .mmu_data_out  (mmu_data_out),
        .mem_req       (mem_req),
        .tag_wr_en     (tag_wr_en),
        .tag_wr_entry  (tag_wr_entry),
        .data_wr_en    (data_wr_en),
        .data_wr_word  (data_wr_word),
        .cache_miss    (cache_miss)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    block_array #(
        .entry_t        (dcache_pkg::tag_entry_t),
        .clear_on_reset (1'b1)                      // Valid and dirty start clear
    ) tag_array (
        .clk      (clk),
        .rst      (rst),
        .rd_index (fields.index),
        .rd_entry (tag_rd_entry),
        .wr_en    (tag_wr_en),
        .wr_index (fields.index),
        .wr_entry (tag_wr_entry)
    );

    block_array #(
        .entry_t        (logic [dcache_pkg::word_width-1:0]),
        .clear_on_reset (1'b0)
    ) data_array (
        .clk      (clk),
        .rst      (rst),
        .rd_index (fields.index),
        .rd_entry (line_word),
        .wr_en    (data_wr_en),
        .wr_index (fields.index),
        .wr_entry (data_wr_word)
    );

    // Load result is only meaningful while cache_miss is low
    access_align align_inst (
        .req        (req),
        .line_word  (line_word),
        .load_data  (data_out),
        .store_word (store_word)
    );

endmodule

`default_nettype wire

//--- testbench/backing_mem.sv
`default_nettype none

// Word-addressed memory model behind the cache.
// A word never written reads back as its word address XOR a fixed pattern
module backing_mem (
    input  wire                         clk,
    input  wire                         rst,
    input  wire  dcache_pkg::mem_req_t  mem_req,
    output logic                        mmu_mem_ready,
    output logic [31:0]                 mmu_data_out,
    output logic [31:0]                 read_count,
    output logic [31:0]                 write_count,
    output logic [31:0]                 last_wr_addr,
    output logic [31:0]                 last_wr_data
);

    localparam int latency = 3;                         // Edges from request rise to ready

    logic [29:0] stored_addr [$];
    logic [31:0] stored_data [$];
    int          wait_count;

    // Later writes override earlier ones, so scan the whole history
    function automatic logic [31:0] lookup(input logic [29:0] word_addr);
        logic [31:0] word;
        word = {2'b00, word_addr} ^ 32'h5a5a0000;
        for (int i = 0; i < stored_addr.size(); i++) begin
            if (stored_addr[i] == word_addr) begin
                word = stored_data[i];
            end
        end
        return word;
    endfunction

    initial begin
        mmu_mem_ready = 1'b0;
        mmu_data_out  = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            mmu_mem_ready <= 1'b0;
            mmu_data_out  <= '0;
            wait_count    <= 0;
            read_count    <= '0;
            write_count   <= '0;
            last_wr_addr  <= '0;
            last_wr_data  <= '0;
        end else if (mmu_mem_ready) begin
            mmu_mem_ready <= 1'b0;                      // Ready is a single-cycle pulse
        end else if (mem_req.read || mem_req.write) begin
            if (wait_count == latency - 1) begin
                wait_count    <= 0;
                mmu_mem_ready <= 1'b1;
                if (mem_req.write) begin
                    stored_addr.push_back(mem_req.addr[31:2]);
                    stored_data.push_back(mem_req.wdata);
                    write_count  <= write_count + 1;
                    last_wr_addr <= mem_req.addr;
                    last_wr_data <= mem_req.wdata;
                end else begin
                    mmu_data_out <= lookup(mem_req.addr[31:2]);
                    read_count   <= read_count + 1;
                end
            end else begin
                wait_count <= wait_count + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/l1_data_cache_tb.sv
`default_nettype none

module l1_data_cache_tb;

    // One table row, expected counts are totals after the row
    typedef struct packed {
        logic              is_write;
        dcache_pkg::size_t size;
        logic              signed_load;
        logic [31:0]       addr;
        logic [31:0]       wdata;
        logic              has_load;
        logic [31:0]       exp_load;
        logic [7:0]        exp_reads;
        logic [7:0]        exp_writes;
    } test_row_t;

    logic                 clk;
    logic                 rst;
    dcache_pkg::cpu_req_t req;
    dcache_pkg::mem_req_t mem_req;
    logic                 mmu_mem_ready;
    logic [31:0]          mmu_data_out;
    logic                 cache_miss;
    logic [31:0]          data_out;
    logic [31:0]          read_count;
    logic [31:0]          write_count;
    logic [31:0]          last_wr_addr;
    logic [31:0]          last_wr_data;

    test_row_t rows [$];
    int        error_count;
    int        check_count;
    int        cycle_count;
    int        cycle_limit;

    l1_data_cache l1_data_cache_inst (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .cache_miss    (cache_miss),
        .data_out      (data_out),
        .mmu_mem_ready (mmu_mem_ready),
        .mmu_data_out  (mmu_data_out),
        .mem_req       (mem_req)
    );

    backing_mem memory_inst (
        .clk           (clk),
        .rst           (rst),
        .mem_req       (mem_req),
        .mmu_mem_ready (mmu_mem_ready),
        .mmu_data_out  (mmu_data_out),
        .read_count    (read_count),
        .write_count   (write_count),
        .last_wr_addr  (last_wr_addr),
        .last_wr_data  (last_wr_data)
    );

    always #20 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic add_row(input bit is_write, input dcache_pkg::size_t size, input bit sgn,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input bit has_load, input logic [31:0] exp_load,
                           input int reads, input int writes);
        test_row_t row;
        row.is_write    = is_write;
        row.size        = size;
        row.signed_load = sgn;
        row.addr        = addr;
        row.wdata       = wdata;
        row.has_load    = has_load;
        row.exp_load    = exp_load;
        row.exp_reads   = reads[7:0];
        row.exp_writes  = writes[7:0];
        rows.push_back(row);
    endtask

    // Line A at index 0x34 holds 5ada80f4 in memory, B shares the index with 5a5a1034,
    // C sits at index 5 with 5a5a0805
    task automatic build_table;
        add_row(0, dcache_pkg::size_word, 0, 32'h020203d0, 32'h0, 1, 32'h5ada80f4, 1, 0);
        add_row(0, dcache_pkg::size_word, 0, 32'h020203d0, 32'h0, 1, 32'h5ada80f4, 1, 0);
        add_row(0, dcache_pkg::size_byte, 0, 32'h020203d0, 32'h0, 1, 32'h000000f4, 1, 0);
        add_row(0, dcache_pkg::size_byte, 1, 32'h020203d0, 32'h0, 1, 32'hfffffff4, 1, 0);
        add_row(0, dcache_pkg::size_byte, 1, 32'h020203d1, 32'h0, 1, 32'hffffff80, 1, 0);
        add_row(0, dcache_pkg::size_byte, 0, 32'h020203d2, 32'h0, 1, 32'h000000da, 1, 0);
        add_row(0, dcache_pkg::size_byte, 1, 32'h020203d2, 32'h0, 1, 32'hffffffda, 1, 0);
        add_row(0, dcache_pkg::size_byte, 1, 32'h020203d3, 32'h0, 1, 32'h0000005a, 1, 0);
        add_row(0, dcache_pkg::size_half, 0, 32'h020203d0, 32'h0, 1, 32'h000080f4, 1, 0);
        add_row(0, dcache_pkg::size_half, 1, 32'h020203d0, 32'h0, 1, 32'hffff80f4, 1, 0);
        add_row(0, dcache_pkg::size_half, 1, 32'h020203d2, 32'h0, 1, 32'h00005ada, 1, 0);
        // Stores into the cached line, nothing goes to memory yet
        add_row(1, dcache_pkg::size_byte, 0, 32'h020203d3, 32'h000000c3, 0, 32'h0, 1, 0);
        add_row(1, dcache_pkg::size_half, 0, 32'h020203d0, 32'h00001234, 0, 32'h0, 1, 0);
        add_row(0, dcache_pkg::size_word, 0, 32'h020203d0, 32'h0, 1, 32'hc3da1234, 1, 0);
        add_row(0, dcache_pkg::size_byte, 1, 32'h020203d3, 32'h0, 1, 32'hffffffc3, 1, 0);
        add_row(0, dcache_pkg::size_half, 1, 32'h020203d2, 32'h0, 1, 32'hffffc3da, 1, 0);
        // B evicts the dirty A, then A comes back from memory
        add_row(0, dcache_pkg::size_word, 0, 32'h000040d0, 32'h0, 1, 32'h5a5a1034, 2, 1);
        add_row(0, dcache_pkg::size_word, 0, 32'h020203d0, 32'h0, 1, 32'hc3da1234, 3, 1);
        // Write miss on a clean index allocates without a write-back
        add_row(1, dcache_pkg::size_half, 0, 32'h00002016, 32'h0000beef, 0, 32'h0, 4, 1);
        add_row(0, dcache_pkg::size_word, 0, 32'h00002014, 32'h0, 1, 32'hbeef0805, 4, 1);
        add_row(0, dcache_pkg::size_byte, 0, 32'h00002016, 32'h0, 1, 32'h000000ef, 4, 1);
        add_row(0, dcache_pkg::size_byte, 0, 32'h020203d1, 32'h0, 1, 32'h00000012, 4, 1);
    endtask

    // Drive on the falling edge, then look a quarter period later when outputs have settled
    task automatic apply_row(input int idx);
        test_row_t row;
        row = rows[idx];
        @(negedge clk);
        req.read        = !row.is_write;
        req.write       = row.is_write;
        req.size        = row.size;
        req.signed_load = row.signed_load;
        req.addr        = row.addr;
        req.wdata       = row.wdata;
        #10;
        while (cache_miss) begin
            @(negedge clk);
            #10;
        end
        if (row.has_load) begin
            check($sformatf("row %0d data_out", idx), data_out, row.exp_load);
        end
        check($sformatf("row %0d memory reads", idx), read_count, {24'h0, row.exp_reads});
        check($sformatf("row %0d memory writes", idx), write_count, {24'h0, row.exp_writes});
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run limit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (!rst) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                $display("Timeout after %0d cycles, the cache never finished the table",
                         cycle_count);
                $display("=== FAIL ===");
                $finish;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        req         = '0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        build_table();
        cycle_limit = rows.size() * 20 + 100;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #10;
        check("cache_miss after reset", {31'h0, cache_miss}, 32'h0);
        check("mem_req.read after reset", {31'h0, mem_req.read}, 32'h0);
        check("mem_req.write after reset", {31'h0, mem_req.write}, 32'h0);

        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end
        @(negedge clk);
        req = '0;

        // The only write-back is the merged A word
        check("last write address", last_wr_addr, 32'h020203d0);
        check("last write data", last_wr_data, 32'hc3da1234);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dcache.f
verilog/dcache_pkg.sv
verilog/block_array.sv
verilog/access_align.sv
verilog/cache_ctrl.sv
verilog/l1_data_cache.sv
testbench/backing_mem.sv
testbench/l1_data_cache_tb.sv
